// File: cu_config.svh
// Encoding constants for the instruction-decode stage.
// Opcodes, instruction field ranges, funct codes and the control-word codes
// driven towards the ALU, stack pointer and branch unit live here.
// Include it wherever a constant is needed; the guard makes repeat includes safe.
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

`define CU_INSTR_W 16 // instruction width
`define CU_REG_W 3 // register number width
`define CU_SHMT_W 4 // shift amount width
`define CU_IMM_W 4 // hash-immediate width

// opcode values
`define CU_OPC_NOP 4'd0
`define CU_OPC_R1 4'd1 // DIV MUL ADD SUB
`define CU_OPC_R2 4'd2 // SHL SHR INC DEC
`define CU_OPC_R3 4'd3 // OR AND NOT MOV
`define CU_OPC_B 4'd4 // jumps on a register
`define CU_OPC_C 4'd5 // flag set / clear
`define CU_OPC_S 4'd6 // PUSH / POP
`define CU_OPC_M 4'd7 // LDD / STD
`define CU_OPC_I 4'd8 // two-word immediate forms
`define CU_OPC_CLRFLAGS 4'd9
`define CU_OPC_CALLR 4'd10

// field ranges inside the instruction word
`define CU_FLD_OPC 15:12
`define CU_FLD_RDST1 11:9
`define CU_FLD_RSRC 8:6
`define CU_FLD_RDST2 5:3
`define CU_FLD_SHMT 5:2
`define CU_FLD_FUNCT 1:0
`define CU_FLD_IFUNCT 2:0
`define CU_FLD_IMM 6:3
`define CU_BIT_OP 11 // C-type: 1 sets, 0 clears
`define CU_BIT_PC 8 // S-type pc select
`define CU_BIT_FLAGS 7 // S-type flags select

// funct codes for S, M and I types
`define CU_FN_PUSH 2'd0
`define CU_FN_POP 2'd1
`define CU_FN_LDD 2'd2
`define CU_FN_STD 2'd3
`define CU_IFN_LDM 3'd0
`define CU_IFN_CALL 3'd1
`define CU_IFN_JMP 3'd2
`define CU_IFN_JC 3'd3
`define CU_IFN_JN 3'd4
`define CU_IFN_JZ 3'd5

// ALU operation codes
`define CU_ALU_ADD 4'd0
`define CU_ALU_SUB 4'd1
`define CU_ALU_INC 4'd2
`define CU_ALU_DEC 4'd3
`define CU_ALU_AND 4'd4
`define CU_ALU_OR 4'd5
`define CU_ALU_NOT 4'd6
`define CU_ALU_SHL 4'd7
`define CU_ALU_SHR 4'd8
`define CU_ALU_MUL 4'd9
`define CU_ALU_DIV 4'd10
`define CU_ALU_MOV 4'd11

`define CU_ALUSRC_REG 2'd0 // operand from register file
`define CU_ALUSRC_DATA 2'd1 // operand from the following data word
`define CU_ALUSRC_SHMT 2'd2 // operand from shmt field

`define CU_SP_KEEP 2'd0
`define CU_SP_DEC 2'd1
`define CU_SP_INC 2'd2

`define CU_JMP_ALWAYS 2'd0
`define CU_JMP_CARRY 2'd1
`define CU_JMP_NEG 2'd2
`define CU_JMP_ZERO 2'd3

`endif

// File: cuPkg.sv
// Shared types of the instruction-decode stage.
// instrKindT names every decoded instruction; the structs carry the registered
// control word and the operand fields out of the stage.
// Modules take the types with a wildcard import in their header.
`default_nettype none
`include "cu_config.svh"

package cuPkg;

	typedef enum logic [5:0] {
		kNop, // also every unknown code
		kAdd, kSub, kInc, kDec, kAnd, kOr, // ALU kinds, keep together
		kNot, kShl, kShr, kMul, kDiv, kMov,
		kJzr, kJnr, kJcr, kJmpr, // jumps through a register
		kSetZ, kSetN, kSetC, kSetInt,
		kClrZ, kClrN, kClrC, kClrInt,
		kPush, kPop, kLdd, kStd,
		kLdm, kCallI, kJmpI, kJcI, kJnI, kJzI, // I-type, second word is the address or data
		kClrFlags,
		kCallR
	} instrKindT;

	// raw pc / flags bits of an S-type word, qualified later by the kind
	typedef struct packed {
		logic pc;
		logic flags;
	} stackSelT;

	typedef struct packed {
		logic zero;
		logic neg;
		logic carry;
		logic intr; // interrupt enable
	} flagVecT;

	typedef struct packed {
		logic [3:0] aluOp; // CU_ALU_* code
		logic [1:0] aluSrc; // CU_ALUSRC_* code
		logic regLowWrite; // write back to rdst1
		logic regHighWrite; // write back to rdst2, MUL upper half
		logic memToReg; // write-back data from memory
		logic memWrite;
		logic memRead;
		logic pcPushPop;
		logic flagsPushPop;
		logic [1:0] spSrc; // CU_SP_* code
		logic memDataSrc; // store pc / flags instead of a register
		logic memAddrSrc; // address from sp instead of a register
		logic isJmp;
		logic jmpSrc; // 1: immediate target, 0: register target
		logic [1:0] jmpType; // CU_JMP_* code
		flagVecT setFlags;
		flagVecT clrFlags;
	} ctrlWordT;

	typedef struct packed {
		logic [`CU_REG_W-1:0] rdst1;
		logic [`CU_REG_W-1:0] rsrc;
		logic [`CU_REG_W-1:0] rdst2;
		logic [`CU_SHMT_W-1:0] shmt;
		logic [`CU_IMM_W-1:0] imm;
	} operandT;

endpackage

`default_nettype wire

// File: instrClassify.sv
// First step of decode: turns the raw 16-bit word into a single instruction kind.
// The later decoders only look at the kind and the S-type stack bits, so all
// opcode / funct knowledge sits here. The operand fields are sliced here too.
// IN, OUT and every unassigned code come out as kNop.
`default_nettype none
`include "cu_config.svh"

module instrClassify import cuPkg::*; (
	input logic [`CU_INSTR_W-1:0] instr,
	output instrKindT kind,
	output stackSelT stackSel,
	output operandT operands
);

	logic [3:0] opcode;
	logic [1:0] funct;
	logic [2:0] iFunct; // I-type has six members, needs three bits
	logic opBit;

	assign opcode = instr[`CU_FLD_OPC];
	assign funct = instr[`CU_FLD_FUNCT];
	assign iFunct = instr[`CU_FLD_IFUNCT];
	assign opBit = instr[`CU_BIT_OP];

	always_comb begin
		kind = kNop;
		case (opcode)
			`CU_OPC_R1: begin
				case (funct)
					2'd0: kind = kDiv;
					2'd1: kind = kMul;
					2'd2: kind = kAdd;
					default: kind = kSub;
				endcase
			end
			`CU_OPC_R2: begin
				case (funct)
					2'd0: kind = kShl;
					2'd1: kind = kShr;
					2'd2: kind = kInc;
					default: kind = kDec;
				endcase
			end
			`CU_OPC_R3: begin
				case (funct)
					2'd0: kind = kOr;
					2'd1: kind = kAnd;
					2'd2: kind = kNot;
					default: kind = kMov;
				endcase
			end
			`CU_OPC_B: begin // funct picks the condition
				case (funct)
					2'd0: kind = kJzr;
					2'd1: kind = kJnr;
					2'd2: kind = kJcr;
					default: kind = kJmpr;
				endcase
			end
			`CU_OPC_C: begin // funct picks the flag, op bit set vs clear
				case (funct)
					2'd0: kind = opBit ? kSetZ : kClrZ;
					2'd1: kind = opBit ? kSetN : kClrN;
					2'd2: kind = opBit ? kSetC : kClrC;
					default: kind = opBit ? kSetInt : kClrInt;
				endcase
			end
			`CU_OPC_S: begin
				if (funct == `CU_FN_PUSH) kind = kPush;
				else if (funct == `CU_FN_POP) kind = kPop;
			end
			`CU_OPC_M: begin // funct 0/1 were OUT / IN, now NOP
				if (funct == `CU_FN_LDD) kind = kLdd;
				else if (funct == `CU_FN_STD) kind = kStd;
			end
			`CU_OPC_I: begin
				case (iFunct)
					`CU_IFN_LDM: kind = kLdm;
					`CU_IFN_CALL: kind = kCallI;
					`CU_IFN_JMP: kind = kJmpI;
					`CU_IFN_JC: kind = kJcI;
					`CU_IFN_JN: kind = kJnI;
					`CU_IFN_JZ: kind = kJzI;
					default: kind = kNop; // iFunct 6, 7 unused
				endcase
			end
			`CU_OPC_CLRFLAGS: kind = kClrFlags;
			`CU_OPC_CALLR: kind = kCallR;
			default: kind = kNop; // opcode 0 and 11..15
		endcase
	end

	assign stackSel.pc = instr[`CU_BIT_PC];
	assign stackSel.flags = instr[`CU_BIT_FLAGS];

	// fields overlap, consumers pick what the kind needs
	assign operands.rdst1 = instr[`CU_FLD_RDST1];
	assign operands.rsrc = instr[`CU_FLD_RSRC];
	assign operands.rdst2 = instr[`CU_FLD_RDST2];
	assign operands.shmt = instr[`CU_FLD_SHMT];
	assign operands.imm = instr[`CU_FLD_IMM];

endmodule

`default_nettype wire

// File: aluCtrlDecode.sv
// ALU side of the control word: operation code, source select and the
// register write-back enables. Purely combinational, driven from the kind.
// Kinds that do not use the ALU get MOV so the datapath passes data through.
`default_nettype none
`include "cu_config.svh"

module aluCtrlDecode import cuPkg::*; (
	input instrKindT kind,
	output logic [3:0] aluOp,
	output logic [1:0] aluSrc,
	output logic regLowWrite,
	output logic regHighWrite,
	output logic memToReg,
	input logic popPcBit // pc bit of the S-type word
);

	logic isAluKind; // any of the twelve R-type kinds
	logic isPop;

	always_comb begin
		aluOp = `CU_ALU_MOV;
		isAluKind = 1'b1;
		case (kind)
			kAdd: aluOp = `CU_ALU_ADD;
			kSub: aluOp = `CU_ALU_SUB;
			kInc: aluOp = `CU_ALU_INC;
			kDec: aluOp = `CU_ALU_DEC;
			kAnd: aluOp = `CU_ALU_AND;
			kOr: aluOp = `CU_ALU_OR;
			kNot: aluOp = `CU_ALU_NOT;
			kShl: aluOp = `CU_ALU_SHL;
			kShr: aluOp = `CU_ALU_SHR;
			kMul: aluOp = `CU_ALU_MUL;
			kDiv: aluOp = `CU_ALU_DIV;
			kMov: aluOp = `CU_ALU_MOV;
			default: isAluKind = 1'b0; // non-ALU kinds keep MOV
		endcase
	end

	always_comb begin
		case (kind)
			kLdm: aluSrc = `CU_ALUSRC_DATA; // data word rides through the ALU
			kShl, kShr: aluSrc = `CU_ALUSRC_SHMT;
			default: aluSrc = `CU_ALUSRC_REG;
		endcase
	end

	assign isPop = (kind == kPop);

	// POP of a register writes rdst1 through the ALU path,
	// POP of pc returns the memory word as write-back data
	assign regLowWrite = isAluKind | (kind == kLdm) | (isPop & ~popPcBit);
	assign regHighWrite = (kind == kMul); // upper half of the product
	assign memToReg = (kind == kLdd) | (isPop & popPcBit);

endmodule

`default_nettype wire

// File: memStackDecode.sv
// Data-memory and stack controls of the control word.
// Covers the read/write strobes, the stack-pointer step and what a PUSH or
// POP moves (register, pc, flags). Calls push the return address, so they
// write memory and step the stack pointer like PUSH does.
`default_nettype none
`include "cu_config.svh"

module memStackDecode import cuPkg::*; (
	input instrKindT kind,
	input stackSelT stackSel,
	output logic memWrite,
	output logic memRead,
	output logic pcPushPop,
	output logic flagsPushPop,
	output logic memDataSrc,
	output logic memAddrSrc,
	output logic [1:0] spSrc
);

	logic isPush;
	logic isPop;
	logic isCall; // either call form

	assign isPush = (kind == kPush);
	assign isPop = (kind == kPop);
	assign isCall = (kind == kCallI) | (kind == kCallR);

	assign memWrite = isPush | (kind == kStd) | isCall;
	assign memRead = isPop | (kind == kLdd);

	always_comb begin
		if (isPop)
			spSrc = `CU_SP_DEC;
		else if (isPush | isCall)
			spSrc = `CU_SP_INC;
		else
			spSrc = `CU_SP_KEEP;
	end

	// stack bits only mean something on an S-type word
	assign pcPushPop = (isPush | isPop) & stackSel.pc;
	assign flagsPushPop = (isPush | isPop) & stackSel.flags;

	assign memDataSrc = isPush & (stackSel.pc | stackSel.flags); // store pc/flags, not rdst
	assign memAddrSrc = isPush | isPop; // address from sp

endmodule

`default_nettype wire

// File: branchFlagDecode.sv
// Branch and flag controls of the control word.
// isJmp / jmpSrc / jmpType steer the fetch stage, setFlags / clrFlags go to the
// flag register. A POP with pc and flags both set is the interrupt return and
// drops the interrupt enable.
`default_nettype none
`include "cu_config.svh"

module branchFlagDecode import cuPkg::*; (
	input instrKindT kind,
	input stackSelT stackSel,
	output logic isJmp,
	output logic jmpSrc,
	output logic [1:0] jmpType,
	output flagVecT setFlags,
	output flagVecT clrFlags
);

	logic isRegJmp;
	logic isImmForm; // all I-type kinds, LDM included
	logic isClrAll;
	logic isRti;

	assign isRegJmp = (kind == kJzr) | (kind == kJnr) | (kind == kJcr) | (kind == kJmpr);
	assign isImmForm = (kind == kLdm) | (kind == kCallI) | (kind == kJmpI)
		| (kind == kJcI) | (kind == kJnI) | (kind == kJzI);

	assign isJmp = isRegJmp | (kind == kCallR) | (isImmForm & (kind != kLdm));
	assign jmpSrc = isImmForm; // only looked at together with isJmp

	always_comb begin
		case (kind)
			kJcr, kJcI: jmpType = `CU_JMP_CARRY;
			kJnr, kJnI: jmpType = `CU_JMP_NEG;
			kJzr, kJzI: jmpType = `CU_JMP_ZERO;
			default: jmpType = `CU_JMP_ALWAYS; // also calls and JMP
		endcase
	end

	assign isClrAll = (kind == kClrFlags);
	assign isRti = (kind == kPop) & stackSel.pc & stackSel.flags;

	assign setFlags.zero = (kind == kSetZ);
	assign setFlags.neg = (kind == kSetN);
	assign setFlags.carry = (kind == kSetC);
	assign setFlags.intr = (kind == kSetInt);

	assign clrFlags.zero = (kind == kClrZ) | isClrAll;
	assign clrFlags.neg = (kind == kClrN) | isClrAll;
	assign clrFlags.carry = (kind == kClrC) | isClrAll;
	assign clrFlags.intr = (kind == kClrInt) | isClrAll | isRti; // RTI re-enables via flag pop

endmodule

`default_nettype wire

// File: ctrlStageReg.sv
// Decode-stage pipeline register.
// An instruction strobed in without flush shows up one cycle later with
// outValid. Any other cycle loads the zero control word, which is a bubble:
// no writes, no jump, stack pointer kept.
`default_nettype none

module ctrlStageReg import cuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic inStrobe,
	input logic flush,
	input ctrlWordT ctrlIn,
	input operandT opIn,
	output logic outValid,
	output ctrlWordT ctrl,
	output operandT operands
);

	logic accept;

	assign accept = inStrobe & ~flush; // flush wins over the strobe

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
			ctrl <= '0;
		end else if (accept) begin
			outValid <= 1'b1;
			ctrl <= ctrlIn;
		end else begin
			outValid <= 1'b0;
			ctrl <= '0; // bubble
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			operands <= opIn; // payload, only meaningful with outValid
	end

endmodule

`default_nettype wire

// File: controlUnit.sv
// Top of the instruction-decode stage.
// instr is classified, three decoders fill disjoint fields of one control
// word, and the stage register presents it one cycle after inStrobe.
// Hook clk / rstN to the core clock and its synchronous active-low reset.
`default_nettype none
`include "cu_config.svh"

module controlUnit import cuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic inStrobe,
	input logic flush,
	input logic [`CU_INSTR_W-1:0] instr,
	output logic outValid,
	output ctrlWordT ctrl,
	output operandT operands
);

	instrKindT kind;
	stackSelT stackSel;
	operandT opNext;
	ctrlWordT ctrlNext; // merged from the three decoders

	instrClassify uClassify (
		.instr(instr),
		.kind(kind),
		.stackSel(stackSel),
		.operands(opNext)
	);

	aluCtrlDecode uAluDec (
		.kind(kind),
		.aluOp(ctrlNext.aluOp),
		.aluSrc(ctrlNext.aluSrc),
		.regLowWrite(ctrlNext.regLowWrite),
		.regHighWrite(ctrlNext.regHighWrite),
		.memToReg(ctrlNext.memToReg),
		.popPcBit(stackSel.pc)
	);

	memStackDecode uMemDec (
		.kind(kind),
		.stackSel(stackSel),
		.memWrite(ctrlNext.memWrite),
		.memRead(ctrlNext.memRead),
		.pcPushPop(ctrlNext.pcPushPop),
		.flagsPushPop(ctrlNext.flagsPushPop),
		.memDataSrc(ctrlNext.memDataSrc),
		.memAddrSrc(ctrlNext.memAddrSrc),
		.spSrc(ctrlNext.spSrc)
	);

	branchFlagDecode uBrDec (
		.kind(kind),
		.stackSel(stackSel),
		.isJmp(ctrlNext.isJmp),
		.jmpSrc(ctrlNext.jmpSrc),
		.jmpType(ctrlNext.jmpType),
		.setFlags(ctrlNext.setFlags),
		.clrFlags(ctrlNext.clrFlags)
	);

	ctrlStageReg uStage (
		.clk(clk),
		.rstN(rstN),
		.inStrobe(inStrobe),
		.flush(flush),
		.ctrlIn(ctrlNext),
		.opIn(opNext),
		.outValid(outValid),
		.ctrl(ctrl),
		.operands(operands)
	);

endmodule

`default_nettype wire

// File: tbControlUnit.sv
// Directed testbench for the instruction-decode stage (controlUnit).
// Each test task drives instruction words on the falling clock edge and checks
// the registered control word and operands against a reference model
// written from the decode rules. Ends with a count line and the verdict.
`default_nettype none
`include "cu_config.svh"

module tbControlUnit import cuPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic rstN;
	logic inStrobe;
	logic flush;
	logic [`CU_INSTR_W-1:0] instr;
	logic outValid;
	ctrlWordT ctrl;
	operandT operands;

	int testsRun, checks, errors, testErrs;
	string curTest;
	logic [31:0] rngState;

	controlUnit UUT (.clk(clk), .rstN(rstN), .inStrobe(inStrobe), .flush(flush),
		.instr(instr), .outValid(outValid), .ctrl(ctrl), .operands(operands));

	always #2 clk = ~clk; // 4 ns period

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// ALU code of an R-type word, group in opc, member in funct
	function automatic logic [3:0] aluCode(input logic [1:0] grp, input logic [1:0] fn);
		case ({grp, fn})
			4'b0100: return `CU_ALU_DIV;
			4'b0101: return `CU_ALU_MUL;
			4'b0110: return `CU_ALU_ADD;
			4'b0111: return `CU_ALU_SUB;
			4'b1000: return `CU_ALU_SHL;
			4'b1001: return `CU_ALU_SHR;
			4'b1010: return `CU_ALU_INC;
			4'b1011: return `CU_ALU_DEC;
			4'b1100: return `CU_ALU_OR;
			4'b1101: return `CU_ALU_AND;
			4'b1110: return `CU_ALU_NOT;
			default: return `CU_ALU_MOV;
		endcase
	endfunction

	// expected control word of one instruction
	function automatic ctrlWordT refCtrl(input logic [15:0] w);
		ctrlWordT c;
		logic [3:0] opc;
		logic [1:0] fn;
		logic [2:0] ifn;
		logic op, pc, fl;
		opc = w[15:12];
		fn = w[1:0];
		ifn = w[2:0];
		op = w[11];
		pc = w[8];
		fl = w[7];
		c = '0;
		c.aluOp = `CU_ALU_MOV; // default for every non-ALU kind
		case (opc)
			4'd1, 4'd2, 4'd3: begin
				c.aluOp = aluCode(opc[1:0], fn);
				c.regLowWrite = 1'b1;
				c.regHighWrite = (opc == 4'd1) && (fn == 2'd1); // MUL
				if (opc == 4'd2 && fn < 2'd2) c.aluSrc = `CU_ALUSRC_SHMT;
			end
			4'd4: begin
				c.isJmp = 1'b1;
				c.jmpType = (fn == 2'd0) ? `CU_JMP_ZERO : (fn == 2'd1) ? `CU_JMP_NEG :
					(fn == 2'd2) ? `CU_JMP_CARRY : `CU_JMP_ALWAYS;
			end
			4'd5: begin
				if (op) c.setFlags = 4'b1000 >> fn; // zero is the top bit
				else c.clrFlags = 4'b1000 >> fn;
			end
			4'd6: begin
				if (fn == 2'd0 || fn == 2'd1) begin
					c.pcPushPop = pc;
					c.flagsPushPop = fl;
					c.memAddrSrc = 1'b1;
				end
				if (fn == 2'd0) begin // PUSH
					c.memWrite = 1'b1;
					c.spSrc = `CU_SP_INC;
					c.memDataSrc = pc | fl;
				end else if (fn == 2'd1) begin // POP
					c.memRead = 1'b1;
					c.spSrc = `CU_SP_DEC;
					c.regLowWrite = ~pc;
					c.memToReg = pc;
					c.clrFlags.intr = pc & fl; // return from interrupt
				end
			end
			4'd7: begin
				c.memRead = (fn == 2'd2);
				c.memToReg = (fn == 2'd2);
				c.memWrite = (fn == 2'd3);
			end
			4'd8: begin
				if (ifn <= 3'd5)
					c.jmpSrc = 1'b1; // every I-type member, LDM too
				if (ifn == 3'd0) begin
					c.aluSrc = `CU_ALUSRC_DATA;
					c.regLowWrite = 1'b1;
				end else if (ifn <= 3'd5) begin
					c.isJmp = 1'b1;
					c.jmpType = (ifn == 3'd3) ? `CU_JMP_CARRY : (ifn == 3'd4) ? `CU_JMP_NEG :
						(ifn == 3'd5) ? `CU_JMP_ZERO : `CU_JMP_ALWAYS;
				end
				if (ifn == 3'd1) begin // CALL on immediate
					c.memWrite = 1'b1;
					c.spSrc = `CU_SP_INC;
				end
			end
			4'd9: c.clrFlags = 4'hF;
			4'd10: begin
				c.isJmp = 1'b1;
				c.memWrite = 1'b1;
				c.spSrc = `CU_SP_INC;
			end
			default: ; // opcodes 0, 11..15
		endcase
		return c;
	endfunction

	function automatic operandT refOps(input logic [15:0] w);
		return {w[11:9], w[8:6], w[5:3], w[5:2], w[6:3]};
	endfunction

	function automatic logic [15:0] rWord(input logic [3:0] opc, input logic [1:0] fn);
		return {opc, 10'h2B5, fn};
	endfunction

	function automatic logic [15:0] sWord(input logic [1:0] fn, input logic pc, input logic fl);
		return {`CU_OPC_S, 3'd3, pc, fl, 5'h0D, fn};
	endfunction

	function automatic logic [15:0] cWord(input logic [1:0] fn, input logic op);
		return {`CU_OPC_C, op, 9'h0D3, fn};
	endfunction

	function automatic logic [15:0] iWord(input logic [2:0] ifn);
		return {`CU_OPC_I, 9'h1A6, ifn};
	endfunction

	task automatic startTest(input string name);
		curTest = name;
		testErrs = 0;
	endtask

	task automatic finishTest();
		testsRun++;
		if (testErrs == 0) $display("test %s: ok", curTest);
		else $display("test %s: %0d errors", curTest, testErrs);
	endtask

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			testErrs++;
			$display("mismatch %s/%s: expected %h, actual %h", curTest, what, exp, act);
		end
	endtask

	// one instruction through the stage, waits for outValid
	task automatic checkInstr(input string what, input logic [15:0] w);
		int cnt;
		cnt = 0;
		@(negedge clk);
		instr = w;
		inStrobe = 1'b1;
		flush = 1'b0;
		@(negedge clk);
		inStrobe = 1'b0;
		while (outValid !== 1'b1 && cnt < 10) begin
			@(negedge clk);
			cnt++;
		end
		if (outValid !== 1'b1) begin
			errors++;
			testErrs++;
			$display("timeout in test %s: outValid did not rise within 10 cycles", curTest);
		end else begin
			compare({what, " ctrl"}, 32'(refCtrl(w)), 32'(ctrl));
			compare({what, " operands"}, 32'(refOps(w)), 32'(operands));
		end
	endtask

	task automatic testReset();
		startTest("reset");
		compare("outValid", 32'd0, 32'(outValid));
		compare("ctrl", 32'd0, 32'(ctrl));
		finishTest();
	endtask

	task automatic testAluTable();
		startTest("aluTable");
		for (int g = 1; g <= 3; g++)
			for (int f = 0; f < 4; f++)
				checkInstr($sformatf("op%0d fn%0d", g, f), rWord(4'(g), 2'(f)));
		checkInstr("unknown opcode", rWord(4'd13, 2'd1));
		compare("unknown aluOp", 32'(`CU_ALU_MOV), 32'(ctrl.aluOp));
		finishTest();
	endtask

	task automatic testStackMem();
		startTest("stackMem");
		checkInstr("PUSH", sWord(`CU_FN_PUSH, 1'b0, 1'b0));
		checkInstr("POP", sWord(`CU_FN_POP, 1'b0, 1'b0));
		checkInstr("PUSH PC", sWord(`CU_FN_PUSH, 1'b1, 1'b0));
		compare("PUSH PC memDataSrc", 32'd1, 32'(ctrl.memDataSrc));
		checkInstr("PUSH FLAGS", sWord(`CU_FN_PUSH, 1'b0, 1'b1));
		checkInstr("RTI", sWord(`CU_FN_POP, 1'b1, 1'b1));
		compare("RTI clr intr", 32'd1, 32'(ctrl.clrFlags.intr));
		compare("RTI memToReg", 32'd1, 32'(ctrl.memToReg));
		checkInstr("LDD", rWord(`CU_OPC_M, `CU_FN_LDD));
		checkInstr("STD", rWord(`CU_OPC_M, `CU_FN_STD));
		checkInstr("M fn0", rWord(`CU_OPC_M, 2'd0)); // old OUT slot
		checkInstr("CALLR", rWord(`CU_OPC_CALLR, 2'd0));
		compare("CALLR spSrc", 32'(`CU_SP_INC), 32'(ctrl.spSrc));
		checkInstr("CALLI", iWord(`CU_IFN_CALL));
		compare("CALLI memWrite", 32'd1, 32'(ctrl.memWrite));
		finishTest();
	endtask

	task automatic testJumps();
		startTest("jumps");
		for (int f = 0; f < 4; f++)
			checkInstr($sformatf("B fn%0d", f), rWord(`CU_OPC_B, 2'(f)));
		for (int f = 0; f < 8; f++)
			checkInstr($sformatf("I fn%0d", f), iWord(3'(f)));
		checkInstr("LDM", iWord(`CU_IFN_LDM));
		compare("LDM isJmp", 32'd0, 32'(ctrl.isJmp));
		compare("LDM aluSrc", 32'(`CU_ALUSRC_DATA), 32'(ctrl.aluSrc));
		finishTest();
	endtask

	task automatic testFlags();
		startTest("flags");
		for (int f = 0; f < 4; f++) begin
			checkInstr($sformatf("SET fn%0d", f), cWord(2'(f), 1'b1));
			checkInstr($sformatf("CLR fn%0d", f), cWord(2'(f), 1'b0));
		end
		checkInstr("CLRFLAGS", rWord(`CU_OPC_CLRFLAGS, 2'd2));
		compare("CLRFLAGS vector", 32'hF, 32'(ctrl.clrFlags));
		finishTest();
	endtask

	// fixed one-cycle latency, so these checks count edges
	task automatic testPipeline();
		logic [15:0] a, b;
		a = rWord(`CU_OPC_R1, 2'd1);
		b = sWord(`CU_FN_POP, 1'b1, 1'b1);
		startTest("pipeline");
		@(negedge clk);
		instr = a;
		inStrobe = 1'b1;
		flush = 1'b0;
		@(negedge clk);
		compare("first valid", 32'd1, 32'(outValid));
		compare("first ctrl", 32'(refCtrl(a)), 32'(ctrl));
		instr = b; // back to back
		@(negedge clk);
		compare("second valid", 32'd1, 32'(outValid));
		compare("second ctrl", 32'(refCtrl(b)), 32'(ctrl));
		inStrobe = 1'b0;
		@(negedge clk);
		compare("idle valid", 32'd0, 32'(outValid));
		compare("idle ctrl", 32'd0, 32'(ctrl));
		instr = a;
		inStrobe = 1'b1;
		flush = 1'b1;
		@(negedge clk);
		compare("flush valid", 32'd0, 32'(outValid));
		compare("flush ctrl", 32'd0, 32'(ctrl));
		inStrobe = 1'b0;
		flush = 1'b0;
		finishTest();
	endtask

	task automatic testRandom();
		startTest("random");
		for (int i = 0; i < 200; i++) begin
			rngState = xorshift(rngState);
			checkInstr($sformatf("word %h", rngState[15:0]), rngState[15:0]);
		end
		finishTest();
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		inStrobe = 1'b0;
		flush = 1'b0;
		instr = '0;
		rngState = 32'd6; // seed
		testsRun = 0;
		checks = 0;
		errors = 0;
		repeat (5) @(negedge clk); // reset for 5 cycles
		rstN = 1'b1;
		testReset();
		testAluTable();
		testStackMem();
		testJumps();
		testFlags();
		testPipeline();
		testRandom();
		$display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
cuPkg.sv
instrClassify.sv
aluCtrlDecode.sv
memStackDecode.sv
branchFlagDecode.sv
ctrlStageReg.sv
controlUnit.sv
tbControlUnit.sv

// File: run.sh
#!/bin/sh
# Builds the decode-stage testbench with Verilator and runs it.
# Exits non-zero on a build error, a simulator error or a failing test.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbControlUnit -f filelist.f -o simControlUnit
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/simControlUnit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" sim.log; then
	exit 1
fi
exit 0
